/* design/csr_pkg.sv */
// RV32 machine mode only; mstatus keeps MIE/MPIE, interrupt fields cover three machine sources
`default_nettype none

package csr_pkg;

  // privilege field of a CSR address, bits 9:8
  typedef enum logic [1:0] {
    priv_user       = 2'b00,
    priv_supervisor = 2'b01,
    priv_hypervisor = 2'b10,
    priv_machine    = 2'b11
  } priv_level_e;

  // access field of a CSR address, bits 11:10
  typedef enum logic [1:0] {
    mode_rw       = 2'b00,
    mode_rw_alt   = 2'b01,
    mode_counter  = 2'b10,
    mode_readonly = 2'b11
  } rw_mode_e;

  // implemented machine CSRs
  localparam logic [11:0] csr_mstatus  = 12'h300;
  localparam logic [11:0] csr_mie      = 12'h304;
  localparam logic [11:0] csr_mtvec    = 12'h305;
  localparam logic [11:0] csr_mscratch = 12'h340;
  localparam logic [11:0] csr_mepc     = 12'h341;
  localparam logic [11:0] csr_mcause   = 12'h342;
  localparam logic [11:0] csr_mip      = 12'h344;
  localparam logic [11:0] csr_mhartid  = 12'hf14;
  localparam logic [11:0] csr_mcycle   = 12'hb00;
  localparam logic [11:0] csr_mcycleh  = 12'hb80;

  // only the interrupt enable stack is kept
  typedef struct packed {
    logic [23:0] zero_hi;
    logic        mpie;
    logic [2:0]  zero_mid;
    logic        mie;
    logic [2:0]  zero_lo;
  } mstatus_t;

  // compact mie / mip, bit 11 / 7 / 3 in the full word
  typedef struct packed {
    logic mei;
    logic mti;
    logic msi;
  } irq_bits_t;

  typedef struct packed {
    logic [29:0] base;
    logic [1:0]  mode;
  } mtvec_t;

  // mode 1 vectors interrupts; 0, 2 and 3 behave as direct
  localparam logic [1:0] mtvec_vectored = 2'd1;

  typedef struct packed {
    logic        irq;
    logic [30:0] code;
  } mcause_t;

  localparam logic [30:0] irq_m_soft  = 31'd3;
  localparam logic [30:0] irq_m_timer = 31'd7;
  localparam logic [30:0] irq_m_ext   = 31'd11;

  // one CSR data word seen as raw bits, as mstatus or as mie/mip
  typedef union packed {
    logic [31:0] raw;
    mstatus_t    status;
    struct packed {
      logic [19:0] pad_hi;
      logic        mei;
      logic [2:0]  pad_mid_hi;
      logic        mti;
      logic [2:0]  pad_mid_lo;
      logic        msi;
      logic [2:0]  pad_lo;
    } irq;
  } csr_word_u;

endpackage

`default_nettype wire

/* design/csr_file.sv */
// machine CSRs only; mscratch/mepc/mcause power up unknown, mcause is trap-written, others read 0
`default_nettype none

module csr_file #(
  parameter int          pc_len  = 30,
  parameter logic [31:0] hart_id = 32'd0
) (
  input  wire                clk,
  input  wire                rst_sync,
  input  wire                stall_n,
  input  wire                csr_ren,
  input  wire                csr_wen,
  input  wire [11:0]         csr_addr,
  input  wire [31:0]         csr_wdata,
  output logic [31:0]        csr_rdata,
  input  wire                trap_taken,
  input  wire                trap_return,
  input  wire [pc_len-1:0]   trap_epc,
  input  wire csr_pkg::mcause_t trap_cause,
  input  wire                mextern_int,
  input  wire                msoftware_int,
  input  wire                mtimer_int,
  output csr_pkg::mstatus_t  mstatus,
  output csr_pkg::irq_bits_t mie,
  output csr_pkg::irq_bits_t mip,
  output csr_pkg::mtvec_t    mtvec,
  output logic [pc_len-1:0]  mepc
);
  import csr_pkg::*;

  localparam int pc_zeros = 32 - pc_len;

  // address fields
  rw_mode_e    rw_mode;
  priv_level_e priv;
  logic [7:0]  short_addr;

  // write qualifiers per register
  logic write_en;
  logic wr_mstatus;
  logic wr_mie;
  logic wr_mtvec;
  logic wr_mscratch;
  logic wr_mepc;

  csr_word_u wr_word;
  mstatus_t  wr_status;
  irq_bits_t wr_irq;

  logic [31:0] mscratch;
  mcause_t     mcause;
  logic [63:0] cycle_cnt;
  logic [31:0] rd_word;

  // spread the three irq bits over a 32-bit word
  function automatic logic [31:0] pad_irq(irq_bits_t bits);
    csr_word_u w;
    w.raw = '0;
    w.irq.mei = bits.mei;
    w.irq.mti = bits.mti;
    w.irq.msi = bits.msi;
    return w.raw;
  endfunction

  // restore the dropped low zero bits of a pc
  function automatic logic [31:0] pad_pc(logic [pc_len-1:0] pc);
    return 32'(pc) << pc_zeros;
  endfunction

  assign rw_mode    = rw_mode_e'(csr_addr[11:10]);
  assign priv       = priv_level_e'(csr_addr[9:8]);
  assign short_addr = csr_addr[7:0];

  // only machine read/write space is writable
  assign write_en    = csr_wen && stall_n && priv == priv_machine && rw_mode == mode_rw;
  assign wr_mstatus  = write_en && short_addr == csr_mstatus[7:0];
  assign wr_mie      = write_en && short_addr == csr_mie[7:0];
  assign wr_mtvec    = write_en && short_addr == csr_mtvec[7:0];
  assign wr_mscratch = write_en && short_addr == csr_mscratch[7:0];
  assign wr_mepc     = write_en && short_addr == csr_mepc[7:0];

  // masked views of the write data
  assign wr_word.raw = csr_wdata;
  always_comb begin
    wr_status      = '0;
    wr_status.mie  = wr_word.status.mie;
    wr_status.mpie = wr_word.status.mpie;
    wr_irq         = '{mei: wr_word.irq.mei, mti: wr_word.irq.mti, msi: wr_word.irq.msi};
  end

  // pending bits follow the interrupt lines directly
  assign mip = '{mei: mextern_int, mti: mtimer_int, msi: msoftware_int};

  // free running, stall does not hold it
  always_ff @(posedge clk, posedge rst_sync) begin
    if (rst_sync) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 64'd1;
    end
  end

  // control registers, software write beats trap stack update
  always_ff @(posedge clk, posedge rst_sync) begin
    if (rst_sync) begin
      mstatus <= '0;
      mie     <= '0;
      mtvec   <= '0;
    end else begin
      if (wr_mstatus) begin
        mstatus <= wr_status;
      end else if (trap_taken) begin
        // push the enable stack
        mstatus.mpie <= mstatus.mie;
        mstatus.mie  <= 1'b0;
      end else if (trap_return) begin
        // pop it again
        mstatus.mie  <= mstatus.mpie;
        mstatus.mpie <= 1'b1;
      end
      if (wr_mie) begin
        mie <= wr_irq;
      end
      if (wr_mtvec) begin
        mtvec <= wr_word.raw;
      end
    end
  end

  // trap payload
  always_ff @(posedge clk) begin
    if (wr_mscratch) begin
      mscratch <= csr_wdata;
    end
    if (wr_mepc) begin
      mepc <= csr_wdata[31:pc_zeros];
    end else if (trap_taken) begin
      mepc <= trap_epc;
    end
    if (trap_taken) begin
      mcause <= trap_cause;
    end
  end

  // read mux
  always_comb begin
    rd_word = '0;
    if (priv == priv_machine) begin
      unique case (rw_mode)
        mode_readonly: begin
          if (short_addr == csr_mhartid[7:0]) rd_word = hart_id;
        end
        mode_counter: begin
          if (short_addr == csr_mcycle[7:0]) rd_word = cycle_cnt[31:0];
          if (short_addr == csr_mcycleh[7:0]) rd_word = cycle_cnt[63:32];
        end
        mode_rw: begin
          case (short_addr)
            csr_mstatus[7:0]:  rd_word = mstatus;
            csr_mie[7:0]:      rd_word = pad_irq(mie);
            csr_mtvec[7:0]:    rd_word = mtvec;
            csr_mscratch[7:0]: rd_word = mscratch;
            csr_mepc[7:0]:     rd_word = pad_pc(mepc);
            csr_mcause[7:0]:   rd_word = mcause;
            csr_mip[7:0]:      rd_word = pad_irq(mip);
            default:           rd_word = '0;
          endcase
        end
        // custom read/write space is not implemented
        default: rd_word = '0;
      endcase
    end
  end

  assign csr_rdata = csr_ren ? rd_word : 32'd0;

endmodule

`default_nettype wire

/* design/trap_ctrl.sv */
// interrupts are taken only at a retire boundary; mtvec modes other than 1 act as direct
`default_nettype none

module trap_ctrl #(
  parameter int pc_len = 30
) (
  input  wire                 clk,
  input  wire                 rst_sync,
  input  wire                 stall_n,
  input  wire                 instr_retire,
  input  wire                 exc_valid,
  input  wire [30:0]          exc_code,
  input  wire [31:0]          exc_pc,
  input  wire [31:0]          retire_next_pc,
  input  wire                 mret,
  input  wire csr_pkg::mstatus_t  mstatus,
  input  wire csr_pkg::irq_bits_t mie,
  input  wire csr_pkg::irq_bits_t mip,
  input  wire csr_pkg::mtvec_t    mtvec,
  input  wire [pc_len-1:0]    mepc,
  output logic                trap_taken,
  output logic                trap_return,
  output logic [pc_len-1:0]   trap_epc,
  output csr_pkg::mcause_t    trap_cause,
  output logic                redirect_valid,
  output logic [31:0]         redirect_pc
);
  import csr_pkg::*;

  localparam int pc_zeros = 32 - pc_len;

  irq_bits_t   irq_pend;
  logic        irq_ready;
  logic [30:0] irq_code;
  logic        take_exc;
  logic        take_irq;
  logic [31:0] base_addr;
  logic [31:0] vec_offset;
  logic [31:0] next_pc;

  // enabled and pending, gated by global enable at a boundary
  assign irq_pend  = mie & mip;
  assign irq_ready = instr_retire && mstatus.mie && (|irq_pend);

  // fixed priority ext then soft then timer
  always_comb begin
    if (irq_pend.mei) begin
      irq_code = irq_m_ext;
    end else if (irq_pend.msi) begin
      irq_code = irq_m_soft;
    end else begin
      irq_code = irq_m_timer;
    end
  end

  // exception over interrupt over mret
  assign take_exc    = stall_n && exc_valid;
  assign take_irq    = stall_n && !exc_valid && irq_ready;
  assign trap_taken  = take_exc || take_irq;
  assign trap_return = stall_n && !exc_valid && !irq_ready && mret;

  // cause and return address for the csr file
  assign trap_cause = take_exc ? '{irq: 1'b0, code: exc_code} : '{irq: 1'b1, code: irq_code};
  assign trap_epc   = take_exc ? exc_pc[31:pc_zeros] : retire_next_pc[31:pc_zeros];

  // handler address
  assign base_addr  = {mtvec.base, 2'b00};
  assign vec_offset = {irq_code[29:0], 2'b00};

  always_comb begin
    if (trap_return) begin
      // back to the saved pc
      next_pc = 32'(mepc) << pc_zeros;
    end else if (take_irq && mtvec.mode == mtvec_vectored) begin
      next_pc = base_addr + vec_offset;
    end else begin
      next_pc = base_addr;
    end
  end

  // one cycle pulse per event
  always_ff @(posedge clk, posedge rst_sync) begin
    if (rst_sync) begin
      redirect_valid <= 1'b0;
    end else begin
      redirect_valid <= trap_taken || trap_return;
    end
  end

  // target held until the next event
  always_ff @(posedge clk) begin
    if (trap_taken || trap_return) begin
      redirect_pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

/* design/m_mode_unit.sv */
// machine mode control block; redirect follows a trap or mret by one cycle, stall_n low holds events
`default_nettype none

module m_mode_unit #(
  parameter int          pc_len  = 30,
  parameter logic [31:0] hart_id = 32'd0
) (
  input  wire         clk,
  input  wire         rst_sync,
  input  wire         stall_n,
  input  wire         instr_retire,
  input  wire         csr_ren,
  input  wire         csr_wen,
  input  wire [11:0]  csr_addr,
  input  wire [31:0]  csr_wdata,
  output logic [31:0] csr_rdata,
  input  wire         exc_valid,
  input  wire [30:0]  exc_code,
  input  wire [31:0]  exc_pc,
  input  wire [31:0]  retire_next_pc,
  input  wire         mret,
  input  wire         mextern_int,
  input  wire         msoftware_int,
  input  wire         mtimer_int,
  output logic        redirect_valid,
  output logic [31:0] redirect_pc
);
  import csr_pkg::*;

  // csr state toward the trap controller
  mstatus_t          mstatus;
  irq_bits_t         mie;
  irq_bits_t         mip;
  mtvec_t            mtvec;
  logic [pc_len-1:0] mepc;

  // trap events back into the csr file
  logic              trap_taken;
  logic              trap_return;
  logic [pc_len-1:0] trap_epc;
  mcause_t           trap_cause;

  csr_file #(
    .pc_len  (pc_len),
    .hart_id (hart_id)
  ) csr_file_inst (
    .clk           (clk),
    .rst_sync      (rst_sync),
    .stall_n       (stall_n),
    .csr_ren       (csr_ren),
    .csr_wen       (csr_wen),
    .csr_addr      (csr_addr),
    .csr_wdata     (csr_wdata),
    .csr_rdata     (csr_rdata),
    .trap_taken    (trap_taken),
    .trap_return   (trap_return),
    .trap_epc      (trap_epc),
    .trap_cause    (trap_cause),
    .mextern_int   (mextern_int),
    .msoftware_int (msoftware_int),
    .mtimer_int    (mtimer_int),
    .mstatus       (mstatus),
    .mie           (mie),
    .mip           (mip),
    .mtvec         (mtvec),
    .mepc          (mepc)
  );

  trap_ctrl #(
    .pc_len (pc_len)
  ) trap_ctrl_inst (
    .clk            (clk),
    .rst_sync       (rst_sync),
    .stall_n        (stall_n),
    .instr_retire   (instr_retire),
    .exc_valid      (exc_valid),
    .exc_code       (exc_code),
    .exc_pc         (exc_pc),
    .retire_next_pc (retire_next_pc),
    .mret           (mret),
    .mstatus        (mstatus),
    .mie            (mie),
    .mip            (mip),
    .mtvec          (mtvec),
    .mepc           (mepc),
    .trap_taken     (trap_taken),
    .trap_return    (trap_return),
    .trap_epc       (trap_epc),
    .trap_cause     (trap_cause),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

endmodule

`default_nettype wire

/* tb/m_mode_unit_chk.sv */
// bound into trap_ctrl; needs clk running while rst_sync is held
`default_nettype none

module m_mode_unit_chk (
  input wire clk,
  input wire rst_sync,
  input wire stall_n,
  input wire instr_retire,
  input wire exc_valid,
  input wire mret,
  input wire trap_taken,
  input wire trap_return,
  input wire redirect_valid
);
  timeunit 1ns;
  timeprecision 1ps;

  // number of failed properties
  int fail_count = 0;

  // redirect held low in reset
  reset_quiet: assert property (@(posedge clk) rst_sync |-> !redirect_valid)
    else begin
      $error("redirect_valid high while reset is asserted");
      fail_count++;
    end

  // trap and return are exclusive
  one_event: assert property (@(posedge clk) disable iff (rst_sync)
    !(trap_taken && trap_return))
    else begin
      $error("trap_taken and trap_return high together");
      fail_count++;
    end

  // an exception or mret always redirects one cycle later
  pulse_after_event: assert property (@(posedge clk) disable iff (rst_sync)
    (stall_n && (exc_valid || mret)) |=> redirect_valid)
    else begin
      $error("no redirect after an exception or mret");
      fail_count++;
    end

  // no redirect without a cause at the inputs
  no_stray_pulse: assert property (@(posedge clk) disable iff (rst_sync)
    !(stall_n && (exc_valid || mret || instr_retire)) |=> !redirect_valid)
    else begin
      $error("redirect_valid without a preceding cause");
      fail_count++;
    end

  // stalled pipeline takes no decision
  stall_blocks: assert property (@(posedge clk) disable iff (rst_sync)
    !stall_n |-> !(trap_taken || trap_return))
    else begin
      $error("trap or return fired while stall_n is low");
      fail_count++;
    end

endmodule

bind trap_ctrl m_mode_unit_chk trap_chk_inst (
  .clk            (clk),
  .rst_sync       (rst_sync),
  .stall_n        (stall_n),
  .instr_retire   (instr_retire),
  .exc_valid      (exc_valid),
  .mret           (mret),
  .trap_taken     (trap_taken),
  .trap_return    (trap_return),
  .redirect_valid (redirect_valid)
);

`default_nettype wire

/* tb/m_mode_unit_tb.sv */
// pc_len 30 assumed; mscratch, mepc and mcause are compared only after the model knows them
`default_nettype none

module m_mode_unit_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import csr_pkg::*;

  localparam int          pc_len  = 30;
  localparam logic [31:0] hart_id = 32'h0000_0005;
  localparam logic [31:0] pc_mask = ~((32'd1 << (32 - pc_len)) - 32'd1);

  // cycles per test, watchdog budget derived from them
  localparam int n_mask  = 400;
  localparam int n_cycle = 200;
  localparam int n_exc   = 400;
  localparam int n_irq   = 600;
  localparam int n_mret  = 300;
  localparam int n_stall = 500;
  localparam int watchdog_ns = (n_mask + n_cycle + n_exc + n_irq + n_mret + n_stall + 20) * 40
                               + 4000;

  logic        clk;
  logic        rst_sync;
  logic        stall_n;
  logic        instr_retire;
  logic        csr_ren;
  logic        csr_wen;
  logic [11:0] csr_addr;
  logic [31:0] csr_wdata;
  logic [31:0] csr_rdata;
  logic        exc_valid;
  logic [30:0] exc_code;
  logic [31:0] exc_pc;
  logic [31:0] retire_next_pc;
  logic        mret;
  logic        mextern_int;
  logic        msoftware_int;
  logic        mtimer_int;
  logic        redirect_valid;
  logic [31:0] redirect_pc;

  // reference state
  logic        m_mie;
  logic        m_mpie;
  logic        m_ie_ext;
  logic        m_ie_tim;
  logic        m_ie_sw;
  logic [31:0] m_mtvec;
  logic [31:0] m_mscratch;
  logic [31:0] m_mepc;
  logic [31:0] m_mcause;
  logic        scratch_known;
  logic        epc_known;
  logic        cause_known;
  logic [63:0] m_cycle;
  logic        exp_rv;
  logic [31:0] exp_rpc;

  integer seed = 32'h93d648dc;
  int     errors;
  int     tests_ok;
  int     tests_bad;
  int     assert_fails;

  m_mode_unit #(
    .pc_len  (pc_len),
    .hart_id (hart_id)
  ) m_mode_unit_inst (
    .clk            (clk),
    .rst_sync       (rst_sync),
    .stall_n        (stall_n),
    .instr_retire   (instr_retire),
    .csr_ren        (csr_ren),
    .csr_wen        (csr_wen),
    .csr_addr       (csr_addr),
    .csr_wdata      (csr_wdata),
    .csr_rdata      (csr_rdata),
    .exc_valid      (exc_valid),
    .exc_code       (exc_code),
    .exc_pc         (exc_pc),
    .retire_next_pc (retire_next_pc),
    .mret           (mret),
    .mextern_int    (mextern_int),
    .msoftware_int  (msoftware_int),
    .mtimer_int     (mtimer_int),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    $display("timeout: run did not complete within %0d ns", watchdog_ns);
    $display("test failed");
    $finish;
  end

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  // implemented CSRs first, then unimplemented and foreign ones
  function automatic logic [11:0] pick_addr(input logic [3:0] sel, input logic [11:0] any);
    case (sel)
      4'd0:    return csr_mstatus;
      4'd1:    return csr_mie;
      4'd2:    return csr_mtvec;
      4'd3:    return csr_mcause;
      4'd4:    return csr_mepc;
      4'd5:    return csr_mscratch;
      4'd6:    return csr_mip;
      4'd7:    return csr_mhartid;
      4'd8:    return csr_mcycle;
      4'd9:    return csr_mcycleh;
      // mtval, sstatus, custom space, mvendorid
      4'd10:   return 12'h343;
      4'd11:   return 12'h100;
      4'd12:   return 12'h7c0;
      4'd13:   return 12'hf11;
      default: return any;
    endcase
  endfunction

  // expected read value from the model
  function automatic logic [31:0] expect_read(input logic [11:0] a, output logic known);
    known = 1'b1;
    case (a)
      csr_mstatus:  return {24'd0, m_mpie, 3'd0, m_mie, 3'd0};
      csr_mie:      return {20'd0, m_ie_ext, 3'd0, m_ie_tim, 3'd0, m_ie_sw, 3'd0};
      csr_mtvec:    return m_mtvec;
      csr_mip:      return {20'd0, mextern_int, 3'd0, mtimer_int, 3'd0, msoftware_int, 3'd0};
      csr_mhartid:  return hart_id;
      csr_mcycle:   return m_cycle[31:0];
      csr_mcycleh:  return m_cycle[63:32];
      csr_mscratch: begin
        known = scratch_known;
        return m_mscratch;
      end
      csr_mepc: begin
        known = epc_known;
        return m_mepc;
      end
      csr_mcause: begin
        known = cause_known;
        return m_mcause;
      end
      default:      return 32'd0;
    endcase
  endfunction

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      errors++;
      $display("** Error at %0t: %s at %h got %h expected %h", $time, what, csr_addr, got, want);
    end
  endtask

  task automatic check_status(input mstatus_t got, input mstatus_t want);
    if (got !== want) begin
      errors++;
      $display("** Error at %0t: mstatus got %h (mie %b mpie %b) expected %h (mie %b mpie %b)",
               $time, got, got.mie, got.mpie, want, want.mie, want.mpie);
    end
  endtask

  task automatic check_redirect(input logic got_v, input logic [31:0] got_pc,
                                input logic want_v, input logic [31:0] want_pc);
    if (got_v !== want_v) begin
      errors++;
      $display("** Error at %0t: redirect_valid got %b expected %b", $time, got_v, want_v);
    end else if (want_v && got_pc !== want_pc) begin
      errors++;
      $display("** Error at %0t: redirect_pc got %h expected %h", $time, got_pc, want_pc);
    end
  endtask

  // random inputs, shaped per test
  task automatic drive_random(input int id);
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] e;
    r = rnd();
    a = rnd();
    e = rnd();
    stall_n        = r[3:0] != 4'd0;
    csr_ren        = r[6:4] != 3'd0;
    csr_wen        = 1'b0;
    csr_addr       = pick_addr(r[13:10], a[11:0]);
    csr_wdata      = rnd();
    exc_valid      = 1'b0;
    exc_code       = e[30:0];
    exc_pc         = rnd();
    retire_next_pc = rnd();
    mret           = 1'b0;
    instr_retire   = 1'b0;
    mextern_int    = r[7];
    msoftware_int  = r[8];
    mtimer_int     = r[9];
    case (id)
      1: begin
        stall_n = r[16];
        csr_wen = r[17] | r[18];
      end
      2: begin
        stall_n  = r[16];
        csr_ren  = 1'b1;
        csr_addr = r[17] ? csr_mcycleh : csr_mcycle;
      end
      3: begin
        exc_valid = r[16:15] == 2'd0;
        csr_wen   = r[19:17] == 3'd0;
      end
      4: begin
        // mstatus, mie, mtvec or mcause, both mtvec modes
        instr_retire   = r[16];
        csr_wen        = r[18:17] == 2'd0;
        csr_addr       = pick_addr({2'b00, r[21:20]}, a[11:0]);
        csr_wdata[1:0] = {1'b0, r[22]};
      end
      5: begin
        mret     = r[16:15] == 2'd0;
        csr_wen  = r[19:17] == 3'd0;
        csr_addr = pick_addr(r[20] ? 4'd4 : 4'd0, a[11:0]);
      end
      default: begin
        stall_n      = r[16];
        exc_valid    = r[17];
        mret         = r[18];
        instr_retire = r[19];
        csr_wen      = r[20] & r[21];
      end
    endcase
  endtask

  task automatic check_outputs();
    logic [31:0] want;
    logic        known;
    want = expect_read(csr_addr, known);
    if (!csr_ren) begin
      want  = 32'd0;
      known = 1'b1;
    end
    if (known && csr_ren && csr_addr == csr_mstatus) begin
      check_status(mstatus_t'(csr_rdata), mstatus_t'(want));
    end else if (known) begin
      check_word("csr_rdata", csr_rdata, want);
    end
    check_redirect(redirect_valid, redirect_pc, exp_rv, exp_rpc);
  endtask

  // state after the coming rising edge
  task automatic model_step();
    logic        wr;
    logic        pend_e;
    logic        pend_s;
    logic        pend_t;
    logic        irq_ok;
    logic        exc;
    logic        trap;
    logic        ret;
    logic [30:0] code;
    logic [31:0] base;
    logic [31:0] target;
    wr     = csr_wen && stall_n && csr_addr[11:8] == 4'h3;
    pend_e = m_ie_ext & mextern_int;
    pend_s = m_ie_sw & msoftware_int;
    pend_t = m_ie_tim & mtimer_int;
    irq_ok = instr_retire && m_mie && (pend_e || pend_s || pend_t);
    code   = pend_e ? 31'd11 : (pend_s ? 31'd3 : 31'd7);
    exc    = stall_n && exc_valid;
    trap   = exc || (stall_n && irq_ok);
    ret    = stall_n && !exc_valid && !irq_ok && mret;
    base   = {m_mtvec[31:2], 2'b00};
    target = base;
    if (ret) begin
      target = m_mepc;
    end else if (!exc && m_mtvec[1:0] == 2'd1) begin
      // vectored interrupt, four bytes per cause
      target = base + 32'(code) * 32'd4;
    end
    exp_rv = trap || ret;
    if (exp_rv) begin
      exp_rpc = target;
    end
    // csr write wins over the trap stack
    if (wr && csr_addr == csr_mstatus) begin
      m_mie  = csr_wdata[3];
      m_mpie = csr_wdata[7];
    end else if (trap) begin
      m_mpie = m_mie;
      m_mie  = 1'b0;
    end else if (ret) begin
      m_mie  = m_mpie;
      m_mpie = 1'b1;
    end
    if (wr && csr_addr == csr_mepc) begin
      m_mepc    = csr_wdata & pc_mask;
      epc_known = 1'b1;
    end else if (trap) begin
      m_mepc    = (exc ? exc_pc : retire_next_pc) & pc_mask;
      epc_known = 1'b1;
    end
    if (trap) begin
      m_mcause    = exc ? {1'b0, exc_code} : {1'b1, code};
      cause_known = 1'b1;
    end
    if (wr && csr_addr == csr_mie) begin
      m_ie_ext = csr_wdata[11];
      m_ie_tim = csr_wdata[7];
      m_ie_sw  = csr_wdata[3];
    end
    if (wr && csr_addr == csr_mtvec) begin
      m_mtvec = csr_wdata;
    end
    if (wr && csr_addr == csr_mscratch) begin
      m_mscratch    = csr_wdata;
      scratch_known = 1'b1;
    end
    m_cycle = m_cycle + 64'd1;
  endtask

  // drive on the falling edge, sample a quarter period later
  task automatic run_test(input int id, input string name, input int cycles);
    int err_start;
    err_start = errors;
    for (int i = 0; i < cycles; i++) begin
      drive_random(id);
      #10;
      check_outputs();
      model_step();
      @(negedge clk);
    end
    if (errors == err_start) begin
      tests_ok++;
    end else begin
      tests_bad++;
    end
    $display("test %0d %s: %s, %0d cycles, %0d mismatches", id, name,
             (errors == err_start) ? "ok" : "FAIL", cycles, errors - err_start);
  endtask

  initial begin
    rst_sync       = 1'b1;
    stall_n        = 1'b1;
    instr_retire   = 1'b0;
    csr_ren        = 1'b0;
    csr_wen        = 1'b0;
    csr_addr       = 12'd0;
    csr_wdata      = 32'd0;
    exc_valid      = 1'b0;
    exc_code       = 31'd0;
    exc_pc         = 32'd0;
    retire_next_pc = 32'd0;
    mret           = 1'b0;
    mextern_int    = 1'b0;
    msoftware_int  = 1'b0;
    mtimer_int     = 1'b0;
    errors         = 0;
    tests_ok       = 0;
    tests_bad      = 0;
    assert_fails   = 0;
    // reset values of the model
    m_mie          = 1'b0;
    m_mpie         = 1'b0;
    m_ie_ext       = 1'b0;
    m_ie_tim       = 1'b0;
    m_ie_sw        = 1'b0;
    m_mtvec        = 32'd0;
    m_mscratch     = 32'd0;
    m_mepc         = 32'd0;
    m_mcause       = 32'd0;
    scratch_known  = 1'b0;
    epc_known      = 1'b0;
    cause_known    = 1'b0;
    m_cycle        = 64'd0;
    exp_rv         = 1'b0;
    exp_rpc        = 32'd0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_sync = 1'b0;
    run_test(1, "csr read/write masking", n_mask);
    run_test(2, "cycle counter", n_cycle);
    run_test(3, "exception trap", n_exc);
    run_test(4, "interrupt priority and vectoring", n_irq);
    run_test(5, "mret", n_mret);
    run_test(6, "stall and priority", n_stall);
    assert_fails = m_mode_unit_inst.trap_ctrl_inst.trap_chk_inst.fail_count;
    $display("summary: %0d ok, %0d bad, %0d mismatches, %0d assertion failures",
             tests_ok, tests_bad, errors, assert_fails);
    if (tests_bad == 0 && assert_fails == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* m_mode_unit.f */
design/csr_pkg.sv
design/csr_file.sv
design/trap_ctrl.sv
design/m_mode_unit.sv
tb/m_mode_unit_chk.sv
tb/m_mode_unit_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --timing --assert
TOP       := m_mode_unit_tb
FILELIST  := m_mode_unit.f

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only if the run prints the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
